//--- rtl/dma_pkg.sv
package dma_pkg;

    // Cache-line address as seen by the memory side
    typedef logic [31:0] line_addr_t;

    // One read command as queued by the register stage
    // Multiline and length keep the bit layout of the LEN register
    typedef struct packed
    {
        line_addr_t       base;
        logic [3:0][31:0] offset;
        logic             multiline;
        logic [30:0]      length;
    } dma_cmd_t;

    // Shared by the request and forward state machines
    typedef enum logic [1:0]
    {
        IDLE,
        PREPROCESS,
        READ,
        DONE
    } engine_state_e;

    // Host register map, byte offsets
    typedef enum logic [7:0]
    {
        BASE   = 8'h00,
        OFF0   = 8'h04,
        OFF1   = 8'h08,
        OFF2   = 8'h0C,
        OFF3   = 8'h10,
        LEN    = 8'h14,
        CTRL   = 8'h18,
        STATUS = 8'h1C
    } reg_addr_e;

endpackage

//--- rtl/mem_pkg.sv
package mem_pkg;

    // Length code of one memory read request
    typedef enum logic [1:0]
    {
        LEN_1 = 2'd0,
        LEN_2 = 2'd1,
        LEN_4 = 2'd3
    } burst_len_e;

    // Request tag carries the running line index
    localparam int TAG_W = 16;

    // Number of cache lines covered by one request
    function automatic logic [2:0] burst_lines(burst_len_e len);
        case (len)
            LEN_2:   return 3'd2;
            LEN_4:   return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

//--- rtl/dma_cmd_if.sv
`timescale 1ns/1ps

interface dma_cmd_if
    import dma_pkg::*;
();
    // Queue head toward the requester
    logic        valid;
    logic        ready;
    dma_cmd_t    cmd;

    // Requester to forwarder, one pulse per accepted command
    logic        start;
    logic [30:0] length;

    // Forwarder back to the register stage
    logic        done;

    modport producer
    (
        output valid, cmd,
        input  ready, done
    );

    modport consumer
    (
        input  valid, cmd,
        output ready, start, length, done
    );

endinterface

//--- rtl/dma_cmd_regs.sv
`timescale 1ns/1ps

module dma_cmd_regs
    import dma_pkg::*;
#(
    parameter int LOG2_CMD_DEPTH = 2
)
(
    input  logic        clk,
    input  logic        reset,

    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [7:0]  s_axi_awaddr,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    input  logic [31:0] s_axi_wdata,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    output logic [1:0]  s_axi_bresp,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    input  logic [7:0]  s_axi_araddr,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,

    input  logic        idle,
    input  logic        active,

    dma_cmd_if.producer cmd
);
    localparam int CMD_DEPTH = 2 ** LOG2_CMD_DEPTH;

    dma_cmd_t                staging;
    logic                    push_pending;
    logic                    write_fire;
    logic                    read_fire;
    logic [15:0]             done_count;

    dma_cmd_t                queue [CMD_DEPTH];
    logic [LOG2_CMD_DEPTH:0] wr_ptr;
    logic [LOG2_CMD_DEPTH:0] rd_ptr;
    logic [LOG2_CMD_DEPTH:0] queue_count;

    // ********************************************************
    // AXI4-Lite handshake
    // ********************************************************

    // AW and W taken together, one write response outstanding
    assign write_fire    = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign s_axi_awready = write_fire;
    assign s_axi_wready  = write_fire;
    assign s_axi_bresp   = 2'b00;

    assign read_fire     = s_axi_arvalid && !s_axi_rvalid;
    assign s_axi_arready = read_fire;
    assign s_axi_rresp   = 2'b00;

    always_ff @(posedge clk)
    begin
        if (write_fire)
        begin
            case (s_axi_awaddr)
                BASE: staging.base      <= s_axi_wdata;
                OFF0: staging.offset[0] <= s_axi_wdata;
                OFF1: staging.offset[1] <= s_axi_wdata;
                OFF2: staging.offset[2] <= s_axi_wdata;
                OFF3: staging.offset[3] <= s_axi_wdata;
                LEN:
                begin
                    staging.multiline <= s_axi_wdata[31];
                    staging.length    <= s_axi_wdata[30:0];
                end
                default: ;
            endcase
        end

        if (read_fire)
        begin
            case (s_axi_araddr)
                BASE:    s_axi_rdata <= staging.base;
                OFF0:    s_axi_rdata <= staging.offset[0];
                OFF1:    s_axi_rdata <= staging.offset[1];
                OFF2:    s_axi_rdata <= staging.offset[2];
                OFF3:    s_axi_rdata <= staging.offset[3];
                LEN:     s_axi_rdata <= {staging.multiline, staging.length};
                STATUS:  s_axi_rdata <= {done_count, 14'd0, active, idle};
                default: s_axi_rdata <= 32'd0;
            endcase
        end
    end

    // ********************************************************
    // Command queue
    // ********************************************************
    assign queue_count = wr_ptr - rd_ptr;
    assign cmd.valid   = (queue_count != 0);
    assign cmd.cmd     = queue[rd_ptr[LOG2_CMD_DEPTH-1:0]];

    // Push one cycle after the CTRL write, full queue drops it
    always_ff @(posedge clk)
    begin
        if (push_pending && queue_count != CMD_DEPTH)
            queue[wr_ptr[LOG2_CMD_DEPTH-1:0]] <= staging;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            push_pending <= 1'b0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            done_count   <= 16'd0;
        end
        else
        begin
            if (write_fire)
                s_axi_bvalid <= 1'b1;
            else if (s_axi_bready)
                s_axi_bvalid <= 1'b0;

            if (read_fire)
                s_axi_rvalid <= 1'b1;
            else if (s_axi_rready)
                s_axi_rvalid <= 1'b0;

            push_pending <= write_fire && (s_axi_awaddr == CTRL) && s_axi_wdata[0];
            if (push_pending && queue_count != CMD_DEPTH)
                wr_ptr <= wr_ptr + 1'b1;
            if (cmd.valid && cmd.ready)
                rd_ptr <= rd_ptr + 1'b1;

            // Completed commands for STATUS
            if (cmd.done)
                done_count <= done_count + 16'd1;
        end
    end

    // Write response held until the host takes it
    assert property (@(posedge clk) disable iff (reset)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

//--- rtl/dma_read_requester.sv
`timescale 1ns/1ps

module dma_read_requester
    import dma_pkg::*;
    import mem_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    dma_cmd_if.consumer        cmd,

    input  logic               mem_almost_full,
    output logic               mem_req_valid,
    output line_addr_t         mem_req_addr,
    output burst_len_e         mem_req_len,
    output logic [TAG_W-1:0]   mem_req_tag,

    input  logic signed [31:0] credit,
    output logic [2:0]         issued_lines,
    output logic               active
);
    engine_state_e    state;

    // Current command
    line_addr_t       running_addr;
    logic [3:0][31:0] offsets;
    logic [1:0]       offset_index;
    logic [30:0]      length;
    logic             multiline;
    logic [31:0]      requested;
    logic             done_seen;

    // Next burst
    logic [31:0]      remaining;
    burst_len_e       burst;
    logic [2:0]       burst_size;
    logic             issue;

    assign cmd.ready = (state == IDLE);
    assign active    = (state != IDLE);

    // ********************************************************
    // Burst selection
    // ********************************************************
    always_comb
    begin
        remaining = {1'b0, length} - requested;

        // Larger bursts only when aligned and enough lines left
        if (multiline && running_addr[1:0] == 2'b00 && remaining >= 32'd4)
            burst = LEN_4;
        else if (multiline && running_addr[0] == 1'b0 && remaining >= 32'd2)
            burst = LEN_2;
        else
            burst = LEN_1;

        burst_size = burst_lines(burst);

        // Wait for credit covering the whole burst
        issue = (state == READ) && (remaining != 32'd0) && !mem_almost_full
            && (credit >= $signed({29'd0, burst_size}));
    end

    // ********************************************************
    // Request state machine
    // ********************************************************
    always_ff @(posedge clk)
    begin
        mem_req_valid <= 1'b0;
        issued_lines  <= 3'd0;
        cmd.start     <= 1'b0;
        if (cmd.done)
            done_seen <= 1'b1;

        case (state)
            IDLE:
            begin
                if (cmd.valid)
                begin
                    running_addr <= cmd.cmd.base;
                    offsets      <= cmd.cmd.offset;
                    length       <= cmd.cmd.length;
                    multiline    <= cmd.cmd.multiline;
                    offset_index <= 2'd0;
                    requested    <= 32'd0;
                    done_seen    <= 1'b0;
                    cmd.start    <= 1'b1;
                    cmd.length   <= cmd.cmd.length;
                    state        <= PREPROCESS;
                end
            end

            PREPROCESS:
            begin
                // One offset per cycle, four cycles
                running_addr <= running_addr + offsets[offset_index];
                offset_index <= offset_index + 2'd1;
                if (offset_index == 2'd3)
                    state <= READ;
            end

            READ:
            begin
                if (issue)
                begin
                    mem_req_valid <= 1'b1;
                    mem_req_addr  <= running_addr;
                    mem_req_len   <= burst;
                    mem_req_tag   <= requested[TAG_W-1:0];
                    issued_lines  <= burst_size;
                    requested     <= requested + 32'(burst_size);
                    running_addr  <= running_addr + 32'(burst_size);
                end
                else if (remaining == 32'd0)
                begin
                    state <= DONE;
                end
            end

            DONE:
            begin
                // Forwarder may finish early on a zero-length command
                if (done_seen || cmd.done)
                    state <= IDLE;
            end
        endcase

        if (reset)
        begin
            state         <= IDLE;
            mem_req_valid <= 1'b0;
            issued_lines  <= 3'd0;
            cmd.start     <= 1'b0;
            done_seen     <= 1'b0;
        end
    end

    // Almost-full at decision time blocks the request that follows
    assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> !$past(mem_almost_full));

endmodule

//--- rtl/dma_read_forwarder.sv
`timescale 1ns/1ps

module dma_read_forwarder
    import dma_pkg::*;
#(
    parameter int LINE_W        = 512,
    parameter int LOG2_PREFETCH = 6
)
(
    input  logic               clk,
    input  logic               reset,

    dma_cmd_if.consumer        cmd,

    input  logic               mem_rsp_valid,
    input  logic [LINE_W-1:0]  mem_rsp_data,

    input  logic [2:0]         issued_lines,
    output logic signed [31:0] credit,

    output logic               out_valid,
    output logic [LINE_W-1:0]  out_data,
    output logic               idle
);
    localparam int DEPTH = 2 ** LOG2_PREFETCH;

    // Prefetch FIFO
    logic [LINE_W-1:0]      prefetch [DEPTH];
    logic [LOG2_PREFETCH:0] wr_ptr;
    logic [LOG2_PREFETCH:0] rd_ptr;
    logic [LOG2_PREFETCH:0] fill;
    logic                   fifo_read;

    logic [31:0]            in_flight;
    engine_state_e          state;
    logic [30:0]            length;
    logic [30:0]            forwarded;

    assign fill      = wr_ptr - rd_ptr;
    assign fifo_read = (fill != 0);

    // Free slots not yet claimed by outstanding or just issued requests
    assign credit = $signed(32'(DEPTH) - 32'(fill) - in_flight - 32'(issued_lines));

    assign idle     = (state == IDLE);
    assign cmd.done = (state == DONE);

    always_ff @(posedge clk)
    begin
        if (mem_rsp_valid)
            prefetch[wr_ptr[LOG2_PREFETCH-1:0]] <= mem_rsp_data;
        if (fifo_read)
            out_data <= prefetch[rd_ptr[LOG2_PREFETCH-1:0]];
    end

    // ********************************************************
    // FIFO pointers and forwarding
    // ********************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_flight <= 32'd0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (mem_rsp_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_read)
                rd_ptr <= rd_ptr + 1'b1;
            out_valid <= fifo_read;
            in_flight <= in_flight + 32'(issued_lines) - 32'(mem_rsp_valid);
        end
    end

    // ********************************************************
    // Completion
    // ********************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (cmd.start)
                    begin
                        length    <= cmd.length;
                        forwarded <= 31'd0;
                        state     <= READ;
                    end
                end

                READ:
                begin
                    if (out_valid)
                        forwarded <= forwarded + 31'd1;
                    if (forwarded == length)
                        state <= DONE;
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Requester credit keeps the prefetch FIFO from overflowing
    assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> fill != DEPTH);

endmodule

//--- rtl/dma_read_top.sv
`timescale 1ns/1ps

module dma_read_top
    import dma_pkg::*;
    import mem_pkg::*;
#(
    parameter int LINE_W         = 512,
    parameter int LOG2_PREFETCH  = 6,
    parameter int LOG2_CMD_DEPTH = 2
)
(
    input  logic              clk,
    input  logic              reset,

    // Host register port
    input  logic              s_axi_awvalid,
    output logic              s_axi_awready,
    input  logic [7:0]        s_axi_awaddr,
    input  logic              s_axi_wvalid,
    output logic              s_axi_wready,
    input  logic [31:0]       s_axi_wdata,
    output logic              s_axi_bvalid,
    input  logic              s_axi_bready,
    output logic [1:0]        s_axi_bresp,
    input  logic              s_axi_arvalid,
    output logic              s_axi_arready,
    input  logic [7:0]        s_axi_araddr,
    output logic              s_axi_rvalid,
    input  logic              s_axi_rready,
    output logic [31:0]       s_axi_rdata,
    output logic [1:0]        s_axi_rresp,

    // Memory read side
    output logic              mem_req_valid,
    output line_addr_t        mem_req_addr,
    output burst_len_e        mem_req_len,
    output logic [TAG_W-1:0]  mem_req_tag,
    input  logic              mem_almost_full,
    input  logic              mem_rsp_valid,
    input  logic [LINE_W-1:0] mem_rsp_data,

    // Line stream
    output logic              out_valid,
    output logic [LINE_W-1:0] out_data
);
    dma_cmd_if          cmd_if ();

    logic signed [31:0] credit;
    logic [2:0]         issued_lines;
    logic               req_active;
    logic               fwd_idle;

    dma_cmd_regs #(
        .LOG2_CMD_DEPTH (LOG2_CMD_DEPTH)
    ) u_cmd_regs (
        .clk,
        .reset,
        .s_axi_awvalid,
        .s_axi_awready,
        .s_axi_awaddr,
        .s_axi_wvalid,
        .s_axi_wready,
        .s_axi_wdata,
        .s_axi_bvalid,
        .s_axi_bready,
        .s_axi_bresp,
        .s_axi_arvalid,
        .s_axi_arready,
        .s_axi_araddr,
        .s_axi_rvalid,
        .s_axi_rready,
        .s_axi_rdata,
        .s_axi_rresp,
        .idle   (fwd_idle && !req_active),
        .active (req_active),
        .cmd    (cmd_if.producer)
    );

    dma_read_requester u_requester (
        .clk,
        .reset,
        .cmd             (cmd_if.consumer),
        .mem_almost_full,
        .mem_req_valid,
        .mem_req_addr,
        .mem_req_len,
        .mem_req_tag,
        .credit,
        .issued_lines,
        .active          (req_active)
    );

    dma_read_forwarder #(
        .LINE_W        (LINE_W),
        .LOG2_PREFETCH (LOG2_PREFETCH)
    ) u_forwarder (
        .clk,
        .reset,
        .cmd           (cmd_if.consumer),
        .mem_rsp_valid,
        .mem_rsp_data,
        .issued_lines,
        .credit,
        .out_valid,
        .out_data,
        .idle          (fwd_idle)
    );

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
    parameter int PERIOD_NS = 20
)
(
    output logic clk
);
    initial
        clk = 1'b0;

    // Half period per phase
    always
        #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
#(
    parameter int LINE_W  = 64,
    parameter int LATENCY = 3
)
(
    input  logic              clk,
    input  logic              af_enable,
    input  logic              req_valid,
    input  logic [31:0]       req_addr,
    input  logic [1:0]        req_len,
    output logic              almost_full,
    output logic              rsp_valid,
    output logic [LINE_W-1:0] rsp_data
);
    // Lines waiting for their response slot, in request order
    logic [31:0] pending_addr [$];
    int          pending_due [$];
    int          cycle;
    int          burst_count;
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        if (value[0])
            return (value >> 1) ^ 32'hA300_0000;
        return value >> 1;
    endfunction

    function automatic int lines_in_burst(input logic [1:0] code);
        case (code)
            2'd1:    return 2;
            2'd3:    return 4;
            default: return 1;
        endcase
    endfunction

    initial
    begin
        almost_full = 1'b0;
        rsp_valid   = 1'b0;
        rsp_data    = '0;
        lfsr        = 32'h8dcc_f1f7;
        cycle       = 0;
    end

    // Requests are stable at the falling edge, responses change there too
    always @(negedge clk)
    begin
        cycle = cycle + 1;
        if (req_valid)
        begin
            burst_count = lines_in_burst(req_len);
            for (int i = 0; i < burst_count; i++)
            begin
                pending_addr.push_back(req_addr + 32'(i));
                pending_due.push_back(cycle + LATENCY);
            end
        end

        if (pending_addr.size() != 0 && pending_due[0] <= cycle)
        begin
            rsp_valid <= 1'b1;
            rsp_data  <= {(LINE_W / 32){pending_addr[0]}};
            void'(pending_addr.pop_front());
            void'(pending_due.pop_front());
        end
        else
        begin
            rsp_valid <= 1'b0;
        end

        // One LFSR step per almost-full bit
        if (af_enable)
        begin
            lfsr = lfsr_next(lfsr);
            almost_full <= lfsr[0];
        end
        else
        begin
            almost_full <= 1'b0;
        end
    end

endmodule

//--- testbench/tb_dma_read.sv
`timescale 1ns/1ps

module tb_dma_read
    import dma_pkg::*;
    import mem_pkg::*;
();
    localparam int LINE_W         = 64;
    // Under 70 lines in all, a few hundred cycles with polling and stalls
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int AXI_WAIT       = 16;
    localparam int POLL_LIMIT     = 400;

    logic              clk;
    logic              reset;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [7:0]        s_axi_awaddr;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic [31:0]       s_axi_wdata;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [7:0]        s_axi_araddr;
    logic              s_axi_rvalid;
    logic              s_axi_rready;
    logic [31:0]       s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              mem_req_valid;
    line_addr_t        mem_req_addr;
    logic [1:0]        mem_req_len;
    logic [TAG_W-1:0]  mem_req_tag;
    logic              mem_almost_full;
    logic              mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_data;
    logic              out_valid;
    logic [LINE_W-1:0] out_data;
    logic              af_enable;

    int error_count;
    int check_count;
    int completed;
    int cycle_count;
    logic [31:0] status_word;

    // Observed and expected traffic of the current test
    logic [31:0]       seen_req_addr [$];
    logic [1:0]        seen_req_len [$];
    logic [TAG_W-1:0]  seen_req_tag [$];
    logic [LINE_W-1:0] seen_out [$];
    logic [31:0]       exp_req_addr [$];
    logic [1:0]        exp_req_len [$];
    logic [TAG_W-1:0]  exp_req_tag [$];
    logic [LINE_W-1:0] exp_out [$];

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk);

    tb_mem_model #(.LINE_W(LINE_W), .LATENCY(3)) u_mem_model (
        .clk,
        .af_enable,
        .req_valid   (mem_req_valid),
        .req_addr    (mem_req_addr),
        .req_len     (mem_req_len),
        .almost_full (mem_almost_full),
        .rsp_valid   (mem_rsp_valid),
        .rsp_data    (mem_rsp_data)
    );

    dma_read_top #(.LINE_W(LINE_W)) u_dma_read_top (.*);

    // ********************************************************
    // Checking and bookkeeping
    // ********************************************************
    task automatic check_equal(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Burst size from alignment and lines left
    function automatic int burst_for(input logic [31:0] addr, input int left,
                                     input logic multiline);
        if (multiline && addr[1:0] == 2'b00 && left >= 4)
            return 4;
        if (multiline && addr[0] == 1'b0 && left >= 2)
            return 2;
        return 1;
    endfunction

    task automatic expect_command(input logic [31:0] base, input logic [3:0][31:0] offsets,
                                  input int lines, input logic multiline);
        logic [31:0] addr;
        int          left;
        int          size;
        int          index;
        addr  = base + offsets[0] + offsets[1] + offsets[2] + offsets[3];
        left  = lines;
        index = 0;
        while (left > 0)
        begin
            size = burst_for(addr, left, multiline);
            exp_req_addr.push_back(addr);
            exp_req_len.push_back(size == 4 ? LEN_4 : (size == 2 ? LEN_2 : LEN_1));
            exp_req_tag.push_back(16'(index));
            for (int i = 0; i < size; i++)
                exp_out.push_back({(LINE_W / 32){addr + 32'(i)}});
            addr  = addr + 32'(size);
            left  = left - size;
            index = index + size;
        end
    endtask

    task automatic clear_records();
        seen_req_addr.delete();
        seen_req_len.delete();
        seen_req_tag.delete();
        seen_out.delete();
        exp_req_addr.delete();
        exp_req_len.delete();
        exp_req_tag.delete();
        exp_out.delete();
    endtask

    task automatic compare_results();
        check_equal("request count", seen_req_addr.size(), exp_req_addr.size());
        if (seen_req_addr.size() == exp_req_addr.size())
        begin
            for (int i = 0; i < exp_req_addr.size(); i++)
            begin
                check_equal("mem_req_addr", seen_req_addr[i], exp_req_addr[i]);
                check_equal("mem_req_len", seen_req_len[i], exp_req_len[i]);
                check_equal("mem_req_tag", seen_req_tag[i], exp_req_tag[i]);
            end
        end
        check_equal("output line count", seen_out.size(), exp_out.size());
        if (seen_out.size() == exp_out.size())
        begin
            for (int i = 0; i < exp_out.size(); i++)
                check_equal("out_data", seen_out[i], exp_out[i]);
        end
        clear_records();
    endtask

    // Memory requests and output lines, sampled away from the rising edge
    always @(negedge clk)
    begin
        if (mem_req_valid)
        begin
            if (mem_almost_full)
            begin
                error_count++;
                $display("Request for line 0x%0h was issued while almost-full was high",
                         mem_req_addr);
            end
            seen_req_addr.push_back(mem_req_addr);
            seen_req_len.push_back(mem_req_len);
            seen_req_tag.push_back(mem_req_tag);
        end
        if (out_valid)
            seen_out.push_back(out_data);
    end

    // ********************************************************
    // AXI4-Lite host tasks
    // ********************************************************
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int   waited;
        logic accepted;
        @(negedge clk);
        s_axi_awvalid = 1'b1;
        s_axi_awaddr  = addr;
        s_axi_wvalid  = 1'b1;
        s_axi_wdata   = data;
        waited   = 0;
        accepted = 1'b0;
        do
        begin
            // Ready values as seen by the rising edge
            @(posedge clk);
            if (s_axi_awready && s_axi_wready)
                accepted = 1'b1;
            @(negedge clk);
            waited++;
        end while (!s_axi_bvalid && waited < AXI_WAIT);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        if (!accepted)
        begin
            error_count++;
            $display("Write to register 0x%0h was never accepted on AW and W", addr);
        end
        if (!s_axi_bvalid)
        begin
            error_count++;
            $display("Write to register 0x%0h never got a write response", addr);
        end
        else
        begin
            check_equal("s_axi_bresp", s_axi_bresp, 2'b00);
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int   waited;
        logic accepted;
        @(negedge clk);
        s_axi_arvalid = 1'b1;
        s_axi_araddr  = addr;
        waited   = 0;
        accepted = 1'b0;
        do
        begin
            @(posedge clk);
            if (s_axi_arready)
                accepted = 1'b1;
            @(negedge clk);
            waited++;
        end while (!s_axi_rvalid && waited < AXI_WAIT);
        s_axi_arvalid = 1'b0;
        data = s_axi_rdata;
        if (!accepted)
        begin
            error_count++;
            $display("Read of register 0x%0h was never accepted on AR", addr);
        end
        if (!s_axi_rvalid)
        begin
            error_count++;
            $display("Read of register 0x%0h never returned data", addr);
        end
        else
        begin
            check_equal("s_axi_rresp", s_axi_rresp, 2'b00);
        end
    endtask

    // ********************************************************
    // Command tasks
    // ********************************************************
    task automatic enqueue_command(input logic [31:0] base, input logic [3:0][31:0] offsets,
                                   input int lines, input logic multiline);
        axi_write(BASE, base);
        axi_write(OFF0, offsets[0]);
        axi_write(OFF1, offsets[1]);
        axi_write(OFF2, offsets[2]);
        axi_write(OFF3, offsets[3]);
        axi_write(LEN, {multiline, 31'(lines)});
        axi_write(CTRL, 32'd1);
        expect_command(base, offsets, lines, multiline);
    endtask

    task automatic wait_for_count(input int target);
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (int'(status[31:16]) != target && polls < POLL_LIMIT)
        begin
            axi_read(STATUS, status);
            polls++;
        end
        if (int'(status[31:16]) != target)
        begin
            error_count++;
            $display("Completed count never reached %0d, STATUS was 0x%0h", target, status);
        end
    endtask

    task automatic check_status(input int target);
        logic [31:0] status;
        axi_read(STATUS, status);
        check_equal("status.idle", status[0], 1);
        check_equal("status.active", status[1], 0);
        check_equal("status.count", status[31:16], target);
    endtask

    task automatic run_command(input logic [31:0] base, input logic [3:0][31:0] offsets,
                               input int lines, input logic multiline);
        clear_records();
        enqueue_command(base, offsets, lines, multiline);
        wait_for_count(completed + 1);
        completed++;
        check_status(completed);
        compare_results();
    endtask

    // ********************************************************
    // Test sequence
    // ********************************************************
    initial
    begin
        reset         = 1'b1;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr  = 8'd0;
        s_axi_wvalid  = 1'b0;
        s_axi_wdata   = 32'd0;
        s_axi_bready  = 1'b1;
        s_axi_arvalid = 1'b0;
        s_axi_araddr  = 8'd0;
        s_axi_rready  = 1'b1;
        af_enable     = 1'b0;
        error_count   = 0;
        check_count   = 0;
        completed     = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        check_status(0);

        // Single lines from 0x10A
        run_command(32'h100, {32'd4, 32'd3, 32'd2, 32'd1}, 5, 1'b0);

        // Unaligned base, bursts grow with alignment
        run_command(32'h201, '0, 21, 1'b1);

        // Second command queued while the first is still running
        clear_records();
        enqueue_command(32'h403, '0, 14, 1'b1);
        enqueue_command(32'h500, {32'd0, 32'd0, 32'd0, 32'd2}, 7, 1'b0);
        axi_read(STATUS, status_word);
        check_equal("status.count", status_word[31:16], completed);
        wait_for_count(completed + 2);
        completed += 2;
        check_status(completed);
        compare_results();

        // Random almost-full from the memory model
        @(posedge clk);
        af_enable = 1'b1;
        run_command(32'h201, '0, 21, 1'b1);
        @(posedge clk);
        af_enable = 1'b0;

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- list.f
rtl/dma_pkg.sv
rtl/mem_pkg.sv
rtl/dma_cmd_if.sv
rtl/dma_cmd_regs.sv
rtl/dma_read_requester.sv
rtl/dma_read_forwarder.sv
rtl/dma_read_top.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_dma_read.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_dma_read

# Output is kept in a variable, the grep status decides the result
sim_output=$(./obj_dir/Vtb_dma_read)
echo "$sim_output"
echo "$sim_output" | grep -q "All tests passed!"
